//--- common/mipsPkg.sv
`default_nettype none

package mipsPkg;

  parameter int dataWidth = 32;
  parameter int regAddrWidth = 5;
  parameter int pcWidth = 8; // Byte address into the instruction port

  // Opcodes in instr[31:26]
  parameter logic [5:0] opRType = 6'b000000;
  parameter logic [5:0] opLw = 6'b100011;
  parameter logic [5:0] opSw = 6'b101011;
  parameter logic [5:0] opBeq = 6'b000100;
  parameter logic [5:0] opAddi = 6'b001000;

  // R-type function codes in instr[5:0]
  parameter logic [5:0] functAdd = 6'b100000;
  parameter logic [5:0] functSub = 6'b100010;
  parameter logic [5:0] functAnd = 6'b100100;
  parameter logic [5:0] functOr = 6'b100101;
  parameter logic [5:0] functSlt = 6'b101010;

  typedef enum logic [2:0] {
    aluAnd = 3'b000,
    aluOr  = 3'b001,
    aluAdd = 3'b010,
    aluSub = 3'b110,
    aluSlt = 3'b111
  } aluCtrlT;

  // Operand source in execute
  typedef enum logic [1:0] {
    fwdReg = 2'b00, // Value read in decode
    fwdWb  = 2'b01, // Result in writeback
    fwdMem = 2'b10  // ALU result in memory
  } fwdSelT;

endpackage

`default_nettype wire

//--- verilog/fetchStage.sv
`timescale 1ns/100ps
`default_nettype none

module fetchStage (
  input  logic                          CLK,
  input  logic                          reset,
  input  logic                          stall,
  input  logic                          flushDecode,
  input  logic                          branchTaken,
  input  logic [mipsPkg::pcWidth-1:0]   branchTarget,
  input  logic [mipsPkg::dataWidth-1:0] instr,
  output logic [mipsPkg::pcWidth-1:0]   pcF,
  output logic [mipsPkg::dataWidth-1:0] instrD,
  output logic [mipsPkg::pcWidth-1:0]   pcPlus4D
);

  localparam logic [mipsPkg::pcWidth-1:0] pcStep = 4;

  logic [mipsPkg::pcWidth-1:0] pcPlus4F;

  assign pcPlus4F = pcF + pcStep;

  // A taken branch redirects even while decode is stalled
  always_ff @(posedge CLK or posedge reset) begin
    if (reset) begin
      pcF <= '0;
    end else if (branchTaken) begin
      pcF <= branchTarget;
    end else if (!stall) begin
      pcF <= pcPlus4F;
    end
  end

  always_ff @(posedge CLK or posedge reset) begin
    if (reset) begin
      instrD <= '0;
      pcPlus4D <= '0;
    end else if (flushDecode) begin
      instrD <= '0; // All-zero word decodes as a no-op
      pcPlus4D <= '0;
    end else if (!stall) begin
      instrD <= instr;
      pcPlus4D <= pcPlus4F;
    end
  end

endmodule

`default_nettype wire

//--- decode/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile (
  input  logic                             CLK,
  input  logic                             reset,
  input  logic [mipsPkg::regAddrWidth-1:0] readAddrA,
  input  logic [mipsPkg::regAddrWidth-1:0] readAddrB,
  input  logic                             writeEnable,
  input  logic [mipsPkg::regAddrWidth-1:0] writeAddr,
  input  logic [mipsPkg::dataWidth-1:0]    writeData,
  output logic [mipsPkg::dataWidth-1:0]    readDataA,
  output logic [mipsPkg::dataWidth-1:0]    readDataB
);

  logic [mipsPkg::dataWidth-1:0] regs [2**mipsPkg::regAddrWidth];
  logic writeLive; // Real write this cycle, never to register zero

  assign writeLive = writeEnable && (writeAddr != '0);

  always_ff @(posedge CLK or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 2**mipsPkg::regAddrWidth; i++) begin
        regs[i] <= '0;
      end
    end else if (writeLive) begin
      regs[writeAddr] <= writeData;
    end
  end

  // Write-through so decode sees the writeback of the same cycle
  assign readDataA = (writeLive && readAddrA == writeAddr) ? writeData : regs[readAddrA];
  assign readDataB = (writeLive && readAddrB == writeAddr) ? writeData : regs[readAddrB];

  assert property (@(posedge CLK) disable iff (reset)
    (readAddrA == '0) |-> (readDataA == '0));

endmodule

`default_nettype wire

//--- decode/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
  input  logic                             CLK,
  input  logic                             reset,
  input  logic                             flushExecute,
  input  logic [mipsPkg::dataWidth-1:0]    instrD,
  input  logic [mipsPkg::pcWidth-1:0]      pcPlus4D,
  input  logic                             regWriteW,
  input  logic [mipsPkg::regAddrWidth-1:0] writeRegW,
  input  logic [mipsPkg::dataWidth-1:0]    resultW,
  output logic [mipsPkg::regAddrWidth-1:0] rsD,
  output logic [mipsPkg::regAddrWidth-1:0] rtD,
  output logic                             regWriteE,
  output logic                             memToRegE,
  output logic                             memWriteE,
  output mipsPkg::aluCtrlT                 aluCtrlE,
  output logic                             aluSrcE,
  output logic                             regDstE,
  output logic                             branchE,
  output logic [mipsPkg::dataWidth-1:0]    rd1E,
  output logic [mipsPkg::dataWidth-1:0]    rd2E,
  output logic [mipsPkg::regAddrWidth-1:0] rsE,
  output logic [mipsPkg::regAddrWidth-1:0] rtE,
  output logic [mipsPkg::regAddrWidth-1:0] rdE,
  output logic [mipsPkg::dataWidth-1:0]    immE,
  output logic [mipsPkg::pcWidth-1:0]      pcPlus4E
);

  logic [5:0] opD, functD;
  logic [mipsPkg::regAddrWidth-1:0] rdD;
  logic [mipsPkg::dataWidth-1:0] immD, rd1D, rd2D;
  logic regWriteD, memToRegD, memWriteD, aluSrcD, regDstD, branchD;
  mipsPkg::aluCtrlT aluCtrlD;

  assign opD = instrD[31:26];
  assign functD = instrD[5:0];
  assign rsD = instrD[25:21];
  assign rtD = instrD[20:16];
  assign rdD = instrD[15:11];
  assign immD = {{(mipsPkg::dataWidth-16){instrD[15]}}, instrD[15:0]};

  registerFile regFile (
    .CLK(CLK),
    .reset(reset),
    .readAddrA(rsD),
    .readAddrB(rtD),
    .writeEnable(regWriteW),
    .writeAddr(writeRegW),
    .writeData(resultW),
    .readDataA(rd1D),
    .readDataB(rd2D)
  );

  // Defaults describe a no-op
  always_comb begin
    regWriteD = 1'b0;
    memToRegD = 1'b0;
    memWriteD = 1'b0;
    aluCtrlD = mipsPkg::aluAdd;
    aluSrcD = 1'b0;
    regDstD = 1'b0;
    branchD = 1'b0;
    case (opD)
      mipsPkg::opRType: begin
        regDstD = 1'b1;
        regWriteD = 1'b1;
        case (functD)
          mipsPkg::functAdd: aluCtrlD = mipsPkg::aluAdd;
          mipsPkg::functSub: aluCtrlD = mipsPkg::aluSub;
          mipsPkg::functAnd: aluCtrlD = mipsPkg::aluAnd;
          mipsPkg::functOr: aluCtrlD = mipsPkg::aluOr;
          mipsPkg::functSlt: aluCtrlD = mipsPkg::aluSlt;
          default: regWriteD = 1'b0; // Unknown funct including sll of the zero word
        endcase
      end
      mipsPkg::opLw: begin
        regWriteD = 1'b1;
        memToRegD = 1'b1;
        aluSrcD = 1'b1;
      end
      mipsPkg::opSw: begin
        memWriteD = 1'b1;
        aluSrcD = 1'b1;
      end
      mipsPkg::opBeq: begin
        branchD = 1'b1;
        aluCtrlD = mipsPkg::aluSub; // Zero flag means equal
      end
      mipsPkg::opAddi: begin
        regWriteD = 1'b1;
        aluSrcD = 1'b1;
      end
      default: ;
    endcase
  end

  // Flush turns the slot into a bubble while data still moves
  always_ff @(posedge CLK or posedge reset) begin
    if (reset) begin
      regWriteE <= 1'b0;
      memToRegE <= 1'b0;
      memWriteE <= 1'b0;
      aluCtrlE <= mipsPkg::aluAnd;
      aluSrcE <= 1'b0;
      regDstE <= 1'b0;
      branchE <= 1'b0;
      rd1E <= '0;
      rd2E <= '0;
      rsE <= '0;
      rtE <= '0;
      rdE <= '0;
      immE <= '0;
      pcPlus4E <= '0;
    end else begin
      regWriteE <= regWriteD & ~flushExecute;
      memToRegE <= memToRegD & ~flushExecute;
      memWriteE <= memWriteD & ~flushExecute;
      aluCtrlE <= flushExecute ? mipsPkg::aluAnd : aluCtrlD;
      aluSrcE <= aluSrcD & ~flushExecute;
      regDstE <= regDstD & ~flushExecute;
      branchE <= branchD & ~flushExecute;
      rd1E <= rd1D;
      rd2E <= rd2D;
      rsE <= rsD;
      rtE <= rtD;
      rdE <= rdD;
      immE <= immD;
      pcPlus4E <= pcPlus4D;
    end
  end

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
`timescale 1ns/100ps
`default_nettype none

module executeStage (
  input  logic                             CLK,
  input  logic                             reset,
  input  logic                             flushMemory,
  input  mipsPkg::fwdSelT                  forwardA,
  input  mipsPkg::fwdSelT                  forwardB,
  input  logic                             regWriteE,
  input  logic                             memToRegE,
  input  logic                             memWriteE,
  input  mipsPkg::aluCtrlT                 aluCtrlE,
  input  logic                             aluSrcE,
  input  logic                             regDstE,
  input  logic                             branchE,
  input  logic [mipsPkg::dataWidth-1:0]    rd1E,
  input  logic [mipsPkg::dataWidth-1:0]    rd2E,
  input  logic [mipsPkg::regAddrWidth-1:0] rtE,
  input  logic [mipsPkg::regAddrWidth-1:0] rdE,
  input  logic [mipsPkg::dataWidth-1:0]    immE,
  input  logic [mipsPkg::pcWidth-1:0]      pcPlus4E,
  input  logic [mipsPkg::dataWidth-1:0]    resultW,
  output logic [mipsPkg::regAddrWidth-1:0] writeRegE,
  output logic                             regWriteM,
  output logic                             memToRegM,
  output logic                             memWriteM,
  output logic                             branchM,
  output logic                             zeroM,
  output logic [mipsPkg::dataWidth-1:0]    aluOutM,
  output logic [mipsPkg::dataWidth-1:0]    writeDataM,
  output logic [mipsPkg::regAddrWidth-1:0] writeRegM,
  output logic [mipsPkg::pcWidth-1:0]      branchTargetM
);

  logic [mipsPkg::dataWidth-1:0] srcA, srcB, writeDataE, aluOutE;
  logic zeroE;
  logic [mipsPkg::pcWidth-1:0] branchTargetE;

  function automatic logic [mipsPkg::dataWidth-1:0] pickOperand(
    input mipsPkg::fwdSelT sel,
    input logic [mipsPkg::dataWidth-1:0] regValue,
    input logic [mipsPkg::dataWidth-1:0] memValue,
    input logic [mipsPkg::dataWidth-1:0] wbValue
  );
    case (sel)
      mipsPkg::fwdMem: return memValue;
      mipsPkg::fwdWb: return wbValue;
      default: return regValue;
    endcase
  endfunction

  assign srcA = pickOperand(forwardA, rd1E, aluOutM, resultW);
  assign writeDataE = pickOperand(forwardB, rd2E, aluOutM, resultW); // Store data too
  assign srcB = aluSrcE ? immE : writeDataE;

  always_comb begin
    case (aluCtrlE)
      mipsPkg::aluAnd: aluOutE = srcA & srcB;
      mipsPkg::aluOr: aluOutE = srcA | srcB;
      mipsPkg::aluSub: aluOutE = srcA - srcB;
      mipsPkg::aluSlt: aluOutE = ($signed(srcA) < $signed(srcB)) ? 1 : 0;
      default: aluOutE = srcA + srcB;
    endcase
  end

  assign zeroE = (aluOutE == '0);
  assign writeRegE = regDstE ? rdE : rtE;
  assign branchTargetE = pcPlus4E + {immE[mipsPkg::pcWidth-3:0], 2'b00}; // Word offset

  always_ff @(posedge CLK or posedge reset) begin
    if (reset) begin
      regWriteM <= 1'b0;
      memToRegM <= 1'b0;
      memWriteM <= 1'b0;
      branchM <= 1'b0;
      zeroM <= 1'b0;
      aluOutM <= '0;
      writeDataM <= '0;
      writeRegM <= '0;
      branchTargetM <= '0;
    end else begin
      regWriteM <= regWriteE & ~flushMemory;
      memToRegM <= memToRegE & ~flushMemory;
      memWriteM <= memWriteE & ~flushMemory;
      branchM <= branchE & ~flushMemory;
      zeroM <= zeroE;
      aluOutM <= aluOutE;
      writeDataM <= writeDataE;
      writeRegM <= writeRegE;
      branchTargetM <= branchTargetE;
    end
  end

  // Hazard unit must not pick the memory stage for register zero
  assert property (@(posedge CLK) disable iff (reset)
    (forwardA == mipsPkg::fwdMem || forwardB == mipsPkg::fwdMem) |-> (writeRegM != '0));

endmodule

`default_nettype wire

//--- verilog/memoryStage.sv
`timescale 1ns/100ps
`default_nettype none

module memoryStage #(
  parameter int dataMemWords = 64
) (
  input  logic                             CLK,
  input  logic                             reset,
  input  logic                             regWriteM,
  input  logic                             memToRegM,
  input  logic                             memWriteM,
  input  logic                             branchM,
  input  logic                             zeroM,
  input  logic [mipsPkg::dataWidth-1:0]    aluOutM,
  input  logic [mipsPkg::dataWidth-1:0]    writeDataM,
  input  logic [mipsPkg::regAddrWidth-1:0] writeRegM,
  input  logic [mipsPkg::pcWidth-1:0]      branchTargetM,
  output logic                             branchTaken,
  output logic [mipsPkg::pcWidth-1:0]      branchTarget,
  output logic                             regWriteW,
  output logic [mipsPkg::regAddrWidth-1:0] writeRegW,
  output logic [mipsPkg::dataWidth-1:0]    resultW
);

  localparam int addrBits = $clog2(dataMemWords);

  logic [mipsPkg::dataWidth-1:0] dataMem [dataMemWords];
  logic [addrBits-1:0] wordAddr;
  logic [mipsPkg::dataWidth-1:0] readDataM, readDataW, aluOutW;
  logic memToRegW;

  assign wordAddr = aluOutM[addrBits+1:2]; // Byte address to word index
  assign readDataM = dataMem[wordAddr];

  always_ff @(posedge CLK) begin
    if (memWriteM) begin
      dataMem[wordAddr] <= writeDataM;
    end
  end

  assign branchTaken = branchM & zeroM;
  assign branchTarget = branchTargetM;

  always_ff @(posedge CLK or posedge reset) begin
    if (reset) begin
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
      writeRegW <= '0;
      readDataW <= '0;
      aluOutW <= '0;
    end else begin
      regWriteW <= regWriteM;
      memToRegW <= memToRegM;
      writeRegW <= writeRegM;
      readDataW <= readDataM;
      aluOutW <= aluOutM;
    end
  end

  assign resultW = memToRegW ? readDataW : aluOutW;

  assert property (@(posedge CLK) disable iff (reset)
    memWriteM |-> (aluOutM[mipsPkg::dataWidth-1:2] < dataMemWords));

endmodule

`default_nettype wire

//--- verilog/hazardUnit.sv
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
  input  logic [mipsPkg::regAddrWidth-1:0] rsD,
  input  logic [mipsPkg::regAddrWidth-1:0] rtD,
  input  logic [mipsPkg::regAddrWidth-1:0] rsE,
  input  logic [mipsPkg::regAddrWidth-1:0] rtE,
  input  logic                             memToRegE,
  input  logic [mipsPkg::regAddrWidth-1:0] writeRegM,
  input  logic                             regWriteM,
  input  logic [mipsPkg::regAddrWidth-1:0] writeRegW,
  input  logic                             regWriteW,
  input  logic                             branchTaken,
  output mipsPkg::fwdSelT                  forwardA,
  output mipsPkg::fwdSelT                  forwardB,
  output logic                             stall,
  output logic                             flushDecode,
  output logic                             flushExecute,
  output logic                             flushMemory
);

  // Memory stage holds the younger result, so it wins over writeback
  function automatic mipsPkg::fwdSelT fwdFrom(
    input logic [mipsPkg::regAddrWidth-1:0] srcReg,
    input logic [mipsPkg::regAddrWidth-1:0] regM,
    input logic                             enM,
    input logic [mipsPkg::regAddrWidth-1:0] regW,
    input logic                             enW
  );
    if (srcReg == '0) begin
      return mipsPkg::fwdReg;
    end else if (enM && srcReg == regM) begin
      return mipsPkg::fwdMem;
    end else if (enW && srcReg == regW) begin
      return mipsPkg::fwdWb;
    end
    return mipsPkg::fwdReg;
  endfunction

  assign forwardA = fwdFrom(rsE, writeRegM, regWriteM, writeRegW, regWriteW);
  assign forwardB = fwdFrom(rtE, writeRegM, regWriteM, writeRegW, regWriteW);

  // Load data only exists after memory, one bubble covers it
  assign stall = memToRegE && (rtE == rsD || rtE == rtD);

  assign flushDecode = branchTaken;
  assign flushExecute = stall | branchTaken;
  assign flushMemory = branchTaken;

endmodule

`default_nettype wire

//--- verilog/mipsCore.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCore #(
  parameter int dataMemWords = 64
) (
  input  logic                             CLK,
  input  logic                             reset,
  input  logic [mipsPkg::dataWidth-1:0]    instr,
  output logic [mipsPkg::pcWidth-1:0]      pcF,
  output logic                             memWrite,
  output logic [mipsPkg::dataWidth-1:0]    memAddr,
  output logic [mipsPkg::dataWidth-1:0]    memWriteData,
  output logic                             regWrite,
  output logic [mipsPkg::regAddrWidth-1:0] writeReg,
  output logic [mipsPkg::dataWidth-1:0]    result
);

  // Fetch to decode
  logic [mipsPkg::dataWidth-1:0] instrD;
  logic [mipsPkg::pcWidth-1:0] pcPlus4D;

  // Decode to execute
  logic [mipsPkg::regAddrWidth-1:0] rsD, rtD, rsE, rtE, rdE;
  logic regWriteE, memToRegE, memWriteE, aluSrcE, regDstE, branchE;
  mipsPkg::aluCtrlT aluCtrlE;
  logic [mipsPkg::dataWidth-1:0] rd1E, rd2E, immE;
  logic [mipsPkg::pcWidth-1:0] pcPlus4E;

  // Execute to memory
  logic regWriteM, memToRegM, memWriteM, branchM, zeroM;
  logic [mipsPkg::dataWidth-1:0] aluOutM, writeDataM;
  logic [mipsPkg::regAddrWidth-1:0] writeRegM;
  logic [mipsPkg::pcWidth-1:0] branchTargetM;

  // Memory back to the earlier stages
  logic branchTaken;
  logic [mipsPkg::pcWidth-1:0] branchTarget;
  logic regWriteW;
  logic [mipsPkg::regAddrWidth-1:0] writeRegW;
  logic [mipsPkg::dataWidth-1:0] resultW;

  // Hazard control
  logic stall, flushDecode, flushExecute, flushMemory;
  mipsPkg::fwdSelT forwardA, forwardB;

  fetchStage fetch (
    .CLK(CLK),
    .reset(reset),
    .stall(stall),
    .flushDecode(flushDecode),
    .branchTaken(branchTaken),
    .branchTarget(branchTarget),
    .instr(instr),
    .pcF(pcF),
    .instrD(instrD),
    .pcPlus4D(pcPlus4D)
  );

  decodeStage decode (
    .CLK(CLK),
    .reset(reset),
    .flushExecute(flushExecute),
    .instrD(instrD),
    .pcPlus4D(pcPlus4D),
    .regWriteW(regWriteW),
    .writeRegW(writeRegW),
    .resultW(resultW),
    .rsD(rsD),
    .rtD(rtD),
    .regWriteE(regWriteE),
    .memToRegE(memToRegE),
    .memWriteE(memWriteE),
    .aluCtrlE(aluCtrlE),
    .aluSrcE(aluSrcE),
    .regDstE(regDstE),
    .branchE(branchE),
    .rd1E(rd1E),
    .rd2E(rd2E),
    .rsE(rsE),
    .rtE(rtE),
    .rdE(rdE),
    .immE(immE),
    .pcPlus4E(pcPlus4E)
  );

  executeStage execute (
    .CLK(CLK),
    .reset(reset),
    .flushMemory(flushMemory),
    .forwardA(forwardA),
    .forwardB(forwardB),
    .regWriteE(regWriteE),
    .memToRegE(memToRegE),
    .memWriteE(memWriteE),
    .aluCtrlE(aluCtrlE),
    .aluSrcE(aluSrcE),
    .regDstE(regDstE),
    .branchE(branchE),
    .rd1E(rd1E),
    .rd2E(rd2E),
    .rtE(rtE),
    .rdE(rdE),
    .immE(immE),
    .pcPlus4E(pcPlus4E),
    .resultW(resultW),
    .writeRegE(),
    .regWriteM(regWriteM),
    .memToRegM(memToRegM),
    .memWriteM(memWriteM),
    .branchM(branchM),
    .zeroM(zeroM),
    .aluOutM(aluOutM),
    .writeDataM(writeDataM),
    .writeRegM(writeRegM),
    .branchTargetM(branchTargetM)
  );

  memoryStage #(
    .dataMemWords(dataMemWords)
  ) memory (
    .CLK(CLK),
    .reset(reset),
    .regWriteM(regWriteM),
    .memToRegM(memToRegM),
    .memWriteM(memWriteM),
    .branchM(branchM),
    .zeroM(zeroM),
    .aluOutM(aluOutM),
    .writeDataM(writeDataM),
    .writeRegM(writeRegM),
    .branchTargetM(branchTargetM),
    .branchTaken(branchTaken),
    .branchTarget(branchTarget),
    .regWriteW(regWriteW),
    .writeRegW(writeRegW),
    .resultW(resultW)
  );

  hazardUnit hazard (
    .rsD(rsD),
    .rtD(rtD),
    .rsE(rsE),
    .rtE(rtE),
    .memToRegE(memToRegE),
    .writeRegM(writeRegM),
    .regWriteM(regWriteM),
    .writeRegW(writeRegW),
    .regWriteW(regWriteW),
    .branchTaken(branchTaken),
    .forwardA(forwardA),
    .forwardB(forwardB),
    .stall(stall),
    .flushDecode(flushDecode),
    .flushExecute(flushExecute),
    .flushMemory(flushMemory)
  );

  // Store port seen in the memory stage, register writes in writeback
  assign memWrite = memWriteM;
  assign memAddr = aluOutM;
  assign memWriteData = writeDataM;
  assign regWrite = regWriteW;
  assign writeReg = writeRegW;
  assign result = resultW;

endmodule

`default_nettype wire

//--- tests/mipsCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCoreTb;

  localparam int maxTests = 16;

  logic CLK;
  logic reset;
  logic [mipsPkg::dataWidth-1:0] instr;
  logic [mipsPkg::pcWidth-1:0] pcF;
  logic memWrite;
  logic [mipsPkg::dataWidth-1:0] memAddr;
  logic [mipsPkg::dataWidth-1:0] memWriteData;
  logic regWrite;
  logic [mipsPkg::regAddrWidth-1:0] writeReg;
  logic [mipsPkg::dataWidth-1:0] result;

  // Program and expected events from the stim file
  logic [31:0] progWords[$];
  int regTestQ[$];
  logic [4:0] regNumQ[$];
  logic [31:0] regValQ[$];
  int storeTestQ[$];
  logic [31:0] storeAddrQ[$];
  logic [31:0] storeValQ[$];

  logic [127:0] testName [maxTests];
  int testLeft [maxTests];
  int testChecks [maxTests];
  int testErrs [maxTests];
  int testCount = 0;
  int testsDone = 0;
  int testsFailed = 0;
  int errorCount = 0;
  int pending = 0; // Expected events not yet seen
  int stimEntries = 0;
  int watchdogCycles = 0;
  int resetErrs = 0;
  bit stimOk = 0;
  bit stimLoaded = 0;
  bit running = 0;

  mipsCore #(
    .dataMemWords(64)
  ) UUT (
    .CLK(CLK),
    .reset(reset),
    .instr(instr),
    .pcF(pcF),
    .memWrite(memWrite),
    .memAddr(memAddr),
    .memWriteData(memWriteData),
    .regWrite(regWrite),
    .writeReg(writeReg),
    .result(result)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  task automatic testIndex(input logic [127:0] name, output int idx);
    idx = -1;
    for (int i = 0; i < testCount; i++) begin
      if (testName[i] == name) idx = i;
    end
    if (idx < 0) begin
      idx = testCount;
      testName[idx] = name;
      testLeft[idx] = 0;
      testChecks[idx] = 0;
      testErrs[idx] = 0;
      testCount++;
    end
  endtask

  task automatic loadStim();
    int fd;
    int n;
    int regNum;
    int t;
    logic [7:0] tag;
    logic [31:0] word;
    logic [31:0] addr;
    logic [31:0] value;
    logic [127:0] name;
    logic [8*200-1:0] skipLine;
    fd = $fopen("tests/coreStim.txt", "r");
    stimOk = (fd != 0);
    if (stimOk) begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", tag);
        if (n != 1) break;
        if (tag == "#") begin
          n = $fgets(skipLine, fd); // Rest of a comment line
        end else if (tag == "I") begin
          n = $fscanf(fd, "%h", word);
          progWords.push_back(word);
          stimEntries++;
        end else if (tag == "W") begin
          n = $fscanf(fd, "%s %d %h", name, regNum, value);
          testIndex(name, t);
          regTestQ.push_back(t);
          regNumQ.push_back(regNum[4:0]);
          regValQ.push_back(value);
          testLeft[t]++;
          pending++;
          stimEntries++;
        end else if (tag == "S") begin
          n = $fscanf(fd, "%s %h %h", name, addr, value);
          testIndex(name, t);
          storeTestQ.push_back(t);
          storeAddrQ.push_back(addr);
          storeValQ.push_back(value);
          testLeft[t]++;
          pending++;
          stimEntries++;
        end else begin
          $display("ERROR: unknown entry kind '%s' in the stim file", tag);
          stimOk = 0;
        end
      end
      $fclose(fd);
    end
  endtask

  // One line per test once its last expected event is consumed
  task automatic finishEntry(input int t);
    pending--;
    testChecks[t]++;
    testLeft[t]--;
    if (testLeft[t] == 0) begin
      $display("test %0s done: %0d checks, %0d errors", testName[t], testChecks[t], testErrs[t]);
      testsDone++;
      if (testErrs[t] > 0) testsFailed++;
    end
  endtask

  task automatic checkRegWrite();
    int t;
    logic [4:0] expNum;
    logic [31:0] expVal;
    assert (regTestQ.size() > 0) else begin
      $display("ERROR: register %0d written with %h after the last expected write",
               writeReg, result);
      errorCount++;
    end
    if (regTestQ.size() > 0) begin
      t = regTestQ.pop_front();
      expNum = regNumQ.pop_front();
      expVal = regValQ.pop_front();
      assert (writeReg == expNum && result == expVal) else begin
        $display("FAILED %0s: expected r%0d = %h, actual r%0d = %h",
                 testName[t], expNum, expVal, writeReg, result);
        errorCount++;
        testErrs[t]++;
      end
      finishEntry(t);
    end
  endtask

  task automatic checkStore();
    int t;
    logic [31:0] expAddr;
    logic [31:0] expVal;
    assert (storeTestQ.size() > 0) else begin
      $display("ERROR: store of %h to address %h after the last expected store",
               memWriteData, memAddr);
      errorCount++;
    end
    if (storeTestQ.size() > 0) begin
      t = storeTestQ.pop_front();
      expAddr = storeAddrQ.pop_front();
      expVal = storeValQ.pop_front();
      assert (memAddr == expAddr && memWriteData == expVal) else begin
        $display("FAILED %0s: expected mem[%h] = %h, actual mem[%h] = %h",
                 testName[t], expAddr, expVal, memAddr, memWriteData);
        errorCount++;
        testErrs[t]++;
      end
      finishEntry(t);
    end
  endtask

  function automatic logic [31:0] fetchWord(input logic [mipsPkg::pcWidth-1:0] addr);
    int idx;
    idx = int'(addr[mipsPkg::pcWidth-1:2]);
    if (idx < progWords.size()) return progWords[idx];
    return '0; // No-op past the end of the program
  endfunction

  // Instruction port answered on the falling edge
  always @(negedge CLK) begin
    instr = fetchWord(pcF);
  end

  // Outputs are stable at the falling edge
  always @(negedge CLK) begin
    if (running) begin
      if (regWrite) checkRegWrite();
      if (memWrite) checkStore();
    end
  end

  task automatic checkResetState();
    assert (pcF == '0 && !regWrite && !memWrite) else begin
      $write("FAILED resetState: expected pcF=00 regWrite=0 memWrite=0, ");
      $display("actual pcF=%h regWrite=%b memWrite=%b", pcF, regWrite, memWrite);
      errorCount++;
      resetErrs++;
    end
  endtask

  initial begin
    reset = 1'b1;
    instr = '0;
    loadStim();
    watchdogCycles = 10 * stimEntries + 200;
    stimLoaded = 1'b1;
    if (!stimOk) begin
      $display("ERROR: could not read tests/coreStim.txt");
      $display("TEST FAIL");
    end else begin
      repeat (8) begin
        @(negedge CLK);
        checkResetState();
      end
      reset = 1'b0;
      checkResetState(); // First cycle out of reset
      running = 1'b1;
      $display("test resetState done: 9 checks, %0d errors", resetErrs);
      testsDone++;
      if (resetErrs > 0) testsFailed++;
      while (pending > 0) @(negedge CLK);
      repeat (10) @(negedge CLK); // Catch stray writes behind the last event
      $display("Summary: %0d tests, %0d failed, %0d errors",
               testsDone, testsFailed, errorCount);
      if (errorCount == 0 && testsFailed == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
    end
    $finish;
  end

  initial begin
    wait (stimLoaded);
    repeat (watchdogCycles) @(posedge CLK);
    $display("ERROR: timeout, expected events still missing after %0d cycles", watchdogCycles);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/coreStim.txt
# I <instruction word hex> | W <test> <register dec> <value hex>
# S <test> <byte address hex> <value hex>
I 20010005
I 2002000C
I 00221820
I 00612022
I 00612824
I 00813025
I 0022382A
I 0041402A
I 00004820
I 200AFFFD
I 0141582A
I AC030008
I 8C0C0008
I 01816820
I AC4D000C
I 10220003
I 200E0007
I 11CE0003
I 200F0063
I AC010000
I 20100001
I 21D10001
I 1000FFFF
# Register writes in program order, squashed slots must stay silent
W aluOps 1 00000005
W aluOps 2 0000000C
W aluOps 3 00000011
W aluOps 4 0000000C
W aluOps 5 00000001
W aluOps 6 0000000D
W aluOps 7 00000001
W aluOps 8 00000000
W zeroSource 9 00000000
W signedSlt 10 FFFFFFFD
W signedSlt 11 00000001
W storeLoad 12 00000011
W storeLoad 13 00000016
W branches 14 00000007
W branches 17 00000008
S storeLoad 00000008 00000011
S storeLoad 00000018 00000016

//--- sim.f
common/mipsPkg.sv
verilog/fetchStage.sv
decode/registerFile.sv
decode/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/hazardUnit.sv
verilog/mipsCore.sv
tests/mipsCoreTb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = mipsCoreTb
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
